//--- Makefile
# Verilator build and run for the ALU issue stage testbench
TOP = aluIssueTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -f all.f -o $(TOP)

# Assertion errors must not stop the run before the summary prints
run: compile
	./obj_dir/$(TOP) +verilator+error+limit+1000 | tee /dev/stderr | \
		grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

//--- all.f
+incdir+source
source/aluIssuePkg.sv
source/issueControl.sv
source/rsEntries.sv
source/aluSelect.sv
source/aluExecute.sv
source/aluIssueTop.sv
tests/aluIssue_assertions.sv
tests/aluIssueTb.sv

//--- source/aluExecute.sv
// Single-cycle ALU with a registered result bus; no stall, so a result is lost if nobody listens
module aluExecute import aluIssuePkg::*; (
	input  logic  clk,
	input  logic  rstN,
	input  logic  issueValid,
	input  aluOpT issueOp,
	input  dataT  issueA,
	input  dataT  issueB,
	input  tagT   issueTag,
	output logic  resultValid,
	output tagT   resultTag,
	output dataT  resultValue
);

	dataT aluOut;
	logic lessThan;                    // Signed compare for opSlt

	assign lessThan = $signed(issueA) < $signed(issueB);

	always_comb begin
		unique case (issueOp)
			opAdd:   aluOut = issueA + issueB;
			opSub:   aluOut = issueA - issueB;
			opAnd:   aluOut = issueA & issueB;
			opOr:    aluOut = issueA | issueB;
			opXor:   aluOut = issueA ^ issueB;
			opSlt:   aluOut = dataT'(lessThan); // Zero-extended flag
			default: aluOut = '0;
		endcase
	end

	// One-cycle valid pulse per issued instruction
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			resultValid <= 1'b0;
		end else begin
			resultValid <= issueValid;
		end
	end

	// Tag and value held between results
	always_ff @(posedge clk) begin
		if (issueValid) begin
			resultTag   <= issueTag;
			resultValue <= aluOut;
		end
	end

endmodule

//--- source/aluIssuePkg.sv
// Shared types for the ALU issue stage; widths come from the params header and nothing here is tunable
`include "aluIssue_params.svh"

package aluIssuePkg;

	// Operand and result payload
	typedef logic [`DATA_WIDTH-1:0] dataT;

	// Name of a result not yet produced
	typedef logic [`TAG_WIDTH-1:0] tagT;

	// One bit per RS entry, for free, ready and grant masks
	typedef logic [`RS_ENTRIES-1:0] slotMaskT;

	// Index of one RS entry
	typedef logic [$clog2(`RS_ENTRIES)-1:0] slotIdxT;

	// ALU function select
	typedef enum logic [`OP_WIDTH-1:0] {
		opAdd = 3'd0,
		opSub = 3'd1,
		opAnd = 3'd2,
		opOr  = 3'd3,
		opXor = 3'd4,
		opSlt = 3'd5 // Signed less-than, 1 or 0
	} aluOpT;

	// Dispatch handshake and flush sequencing
	typedef enum logic [1:0] {
		stIdle,
		stAck,
		stFlush
	} ctrlStateT;

endpackage

//--- source/aluIssueTop.sv
// ALU issue stage top; wakeup comes only from its own result bus, which has no back-pressure
module aluIssueTop import aluIssuePkg::*; (
	input  logic  clk,
	input  logic  rstN,
	input  logic  dispatchReq,
	input  aluOpT dispatchOp,
	input  dataT  srcAValue,
	input  tagT   srcATag,
	input  logic  srcAReady,
	input  dataT  srcBValue,
	input  tagT   srcBTag,
	input  logic  srcBReady,
	input  tagT   destTag,
	output logic  dispatchAck,
	input  logic  flush,
	output logic  resultValid,
	output tagT   resultTag,
	output dataT  resultValue,
	output logic  full
);

	logic     allocEn;
	slotIdxT  allocSlot;
	logic     flushAll;
	slotMaskT freeMask;
	slotMaskT readyMask;
	slotMaskT grant;                   // One-hot from the selector
	logic     issueValid;
	aluOpT    issueOp;
	dataT     issueA;
	dataT     issueB;
	tagT      issueTag;

	issueControl uControl (
		.clk, .rstN, .dispatchReq, .flush, .freeMask,
		.dispatchAck, .allocEn, .allocSlot, .flushAll, .full
	);

	// Result bus loops back here for wakeup
	rsEntries uEntries (
		.clk, .rstN, .allocEn, .allocSlot, .dispatchOp,
		.srcAValue, .srcBValue, .srcATag, .srcBTag, .destTag,
		.srcAReady, .srcBReady, .grant, .flushAll,
		.resultValid, .resultTag, .resultValue,
		.freeMask, .readyMask, .issueValid,
		.issueOp, .issueA, .issueB, .issueTag
	);

	aluSelect uSelect (
		.clk, .rstN, .readyMask, .flushAll, .grant
	);

	aluExecute uExecute (
		.clk, .rstN, .issueValid, .issueOp, .issueA, .issueB, .issueTag,
		.resultValid, .resultTag, .resultValue
	);

endmodule

//--- source/aluIssue_params.svh
// Width and depth macros; slotIdxT is sized by $clog2, so RS_ENTRIES must be a power of two
`ifndef ALUISSUE_PARAMS_SVH
`define ALUISSUE_PARAMS_SVH

// Operand and result width
`define DATA_WIDTH 32

// Result tag width, set by the upstream renamer
`define TAG_WIDTH 4

// Reservation station depth
`define RS_ENTRIES 4

// Opcode field width, must fit every aluOpT member
`define OP_WIDTH 3

`endif

//--- source/aluSelect.sv
// Round-robin grant, combinational from readyMask; grant is forced low while flushAll is high
`include "aluIssue_params.svh"

module aluSelect import aluIssuePkg::*; (
	input  logic     clk,
	input  logic     rstN,
	input  slotMaskT readyMask,
	input  logic     flushAll,
	output slotMaskT grant
);

	slotIdxT pointer;                  // Highest priority slot this cycle
	slotIdxT grantIdx;                 // Index of the granted slot
	slotIdxT nextPtr;

	// Search from pointer upward, wrapping at the top
	always_comb begin
		int   idx;
		logic found;
		idx      = 0;
		found    = 1'b0;
		grant    = '0;
		grantIdx = '0;
		for (int k = 0; k < `RS_ENTRIES; k++) begin
			idx = (int'(pointer) + k) % `RS_ENTRIES;
			if (!found && readyMask[idx]) begin
				found       = 1'b1;
				grant[idx]  = 1'b1;
				grantIdx    = slotIdxT'(idx);
			end
		end
		if (flushAll) grant = '0;   // No issue out of a dying window
	end

	// Slot after the winner takes priority next
	assign nextPtr = (grantIdx == slotIdxT'(`RS_ENTRIES - 1)) ? '0 : grantIdx + 1'b1;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pointer <= '0;
		end else if (flushAll) begin
			pointer <= '0;
		end else if (|grant) begin
			pointer <= nextPtr;
		end                            // Idle cycles keep the pointer
	end

endmodule

//--- source/issueControl.sv
// Dispatch FSM for a four-phase req/ack; the producer must hold its fields until ack, and full lags a cycle
`include "aluIssue_params.svh"

module issueControl import aluIssuePkg::*; (
	input  logic     clk,
	input  logic     rstN,
	input  logic     dispatchReq,
	input  logic     flush,
	input  slotMaskT freeMask,
	output logic     dispatchAck,
	output logic     allocEn,
	output slotIdxT  allocSlot,
	output logic     flushAll,
	output logic     full
);

	ctrlStateT state;
	ctrlStateT nextState;
	slotIdxT   freeSlot;               // Lowest free entry
	logic      anyFree;

	// Lowest index wins, scan from the top down
	always_comb begin
		freeSlot = '0;
		for (int i = `RS_ENTRIES - 1; i >= 0; i--) begin
			if (freeMask[i]) freeSlot = slotIdxT'(i);
		end
	end

	assign anyFree = |freeMask;

	always_comb begin
		nextState = state;
		allocEn   = 1'b0;
		unique case (state)
			stIdle: begin
				if (flush) begin
					nextState = stFlush;   // Flush beats a pending request
				end else if (dispatchReq && anyFree) begin
					allocEn   = 1'b1;
					nextState = stAck;
				end
			end
			stAck: begin
				// Hold ack until the producer lets go of req
				if (!dispatchReq) nextState = flush ? stFlush : stIdle;
			end
			stFlush: nextState = flush ? stFlush : stIdle;
			default: nextState = stIdle;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= stIdle;
			full  <= 1'b0;
		end else begin
			state <= nextState;
			full  <= !anyFree;
		end
	end

	assign allocSlot   = freeSlot;
	assign dispatchAck = (state == stAck);
	// Raw flush clears at once, stFlush keeps the window shut one more cycle
	assign flushAll    = flush || (state == stFlush);

endmodule

//--- source/rsEntries.sv
// RS storage; wakeup only from this ALU's result bus, grant must be one-hot and only on valid entries
`include "aluIssue_params.svh"

module rsEntries import aluIssuePkg::*; (
	input  logic     clk,
	input  logic     rstN,
	input  logic     allocEn,
	input  slotIdxT  allocSlot,
	input  aluOpT    dispatchOp,
	input  dataT     srcAValue,
	input  dataT     srcBValue,
	input  tagT      srcATag,
	input  tagT      srcBTag,
	input  tagT      destTag,
	input  logic     srcAReady,
	input  logic     srcBReady,
	input  slotMaskT grant,
	input  logic     flushAll,
	input  logic     resultValid,
	input  tagT      resultTag,
	input  dataT     resultValue,
	output slotMaskT freeMask,
	output slotMaskT readyMask,
	output logic     issueValid,
	output aluOpT    issueOp,
	output dataT     issueA,
	output dataT     issueB,
	output tagT      issueTag
);

	slotMaskT valid;                   // Entry occupied
	slotMaskT aReady;                  // Operand A holds a value
	slotMaskT bReady;
	aluOpT    opQ  [`RS_ENTRIES];
	dataT     aVal [`RS_ENTRIES];
	dataT     bVal [`RS_ENTRIES];
	tagT      aTag [`RS_ENTRIES];
	tagT      bTag [`RS_ENTRIES];
	tagT      dTag [`RS_ENTRIES];      // Destination tag

	slotMaskT allocHit;                // One-hot write select
	slotMaskT wakeA;
	slotMaskT wakeB;
	logic     allocWakeA;              // Result lands in the dispatch cycle
	logic     allocWakeB;

	// Bypass for a result broadcast while the instruction is being written
	assign allocWakeA = !srcAReady && resultValid && (resultTag == srcATag);
	assign allocWakeB = !srcBReady && resultValid && (resultTag == srcBTag);

	always_comb begin
		for (int i = 0; i < `RS_ENTRIES; i++) begin
			allocHit[i] = allocEn && (allocSlot == slotIdxT'(i));
			// Tag compare against the result bus, waiting operands only
			wakeA[i] = valid[i] && !aReady[i] && resultValid && (resultTag == aTag[i]);
			wakeB[i] = valid[i] && !bReady[i] && resultValid && (resultTag == bTag[i]);
		end
	end

	// Occupancy and operand readiness
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			valid  <= '0;
			aReady <= '0;
			bReady <= '0;
		end else if (flushAll) begin
			valid <= '0;                   // Drop everything, ready bits are don't-care now
		end else begin
			for (int i = 0; i < `RS_ENTRIES; i++) begin
				if (allocHit[i]) begin
					valid[i]  <= 1'b1;
					aReady[i] <= srcAReady || allocWakeA;
					bReady[i] <= srcBReady || allocWakeB;
				end else begin
					if (grant[i]) valid[i] <= 1'b0; // Freed on issue
					if (wakeA[i]) aReady[i] <= 1'b1;
					if (wakeB[i]) bReady[i] <= 1'b1;
				end
			end
		end
	end

	// Payload, written on alloc and patched on wakeup
	always_ff @(posedge clk) begin
		for (int i = 0; i < `RS_ENTRIES; i++) begin
			if (allocHit[i]) begin
				opQ[i]  <= dispatchOp;
				aVal[i] <= allocWakeA ? resultValue : srcAValue;
				bVal[i] <= allocWakeB ? resultValue : srcBValue;
				aTag[i] <= srcATag;
				bTag[i] <= srcBTag;
				dTag[i] <= destTag;
			end else begin
				if (wakeA[i]) aVal[i] <= resultValue;
				if (wakeB[i]) bVal[i] <= resultValue;
			end
		end
	end

	assign freeMask   = ~valid;
	assign readyMask  = valid & aReady & bReady;
	assign issueValid = |grant;

	// Read port, grant is one-hot so the last hit is the only hit
	always_comb begin
		issueOp  = opAdd;
		issueA   = '0;
		issueB   = '0;
		issueTag = '0;
		for (int i = 0; i < `RS_ENTRIES; i++) begin
			if (grant[i]) begin
				issueOp  = opQ[i];
				issueA   = aVal[i];
				issueB   = bVal[i];
				issueTag = dTag[i];
			end
		end
	end

endmodule

//--- tests/aluIssueTb.sv
// ALU issue stage testbench; tags are reused between tests, so each test drains before the next
`include "aluIssue_params.svh"

module aluIssueTb import aluIssuePkg::*;;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int dispatchCount  = 31;   // Dispatches over all tests
	localparam int watchdogCycles = 40 * dispatchCount + 200;

	logic clk, rstN, dispatchReq, srcAReady, srcBReady, flush;
	aluOpT dispatchOp;
	dataT srcAValue, srcBValue, resultValue;
	tagT srcATag, srcBTag, destTag, resultTag;
	logic dispatchAck, resultValid, full;

	int seed = 32'h74cb;
	int tbErrors = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int errorsBefore = 0;
	dataT expValue [1 << `TAG_WIDTH];      // Reference model, tag to value
	logic [(1 << `TAG_WIDTH)-1:0] pending = '0; // Tags owed on the result bus

	aluIssueTop dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic dataT randomValue();
		return dataT'($random(seed));
	endfunction

	function automatic dataT aluModel(input aluOpT op, input dataT a, input dataT b);
		case (op)
			opAdd: return a + b;
			opSub: return a - b;
			opAnd: return a & b;
			opOr:  return a | b;
			opXor: return a ^ b;
			default: return ($signed(a) < $signed(b)) ? dataT'(1) : dataT'(0); // Signed compare
		endcase
	endfunction

	function automatic int totalErrors();
		return tbErrors + dut.uAsserts.failCount;
	endfunction

	// Operand field is a value when ready, else a source tag
	task automatic sendOp(input aluOpT op, input logic aRdy, input dataT aField,
			input logic bRdy, input dataT bField, input tagT dest);
		dataT a;
		dataT b;
		a = aRdy ? aField : expValue[tagT'(aField)];
		b = bRdy ? bField : expValue[tagT'(bField)];
		expValue[dest] = aluModel(op, a, b);
		pending[dest] = 1'b1;
		@(posedge clk);
		dispatchReq <= 1'b1;
		dispatchOp  <= op;
		srcAReady   <= aRdy;
		srcAValue   <= aRdy ? aField : '0;
		srcATag     <= aRdy ? '0 : tagT'(aField);
		srcBReady   <= bRdy;
		srcBValue   <= bRdy ? bField : '0;
		srcBTag     <= bRdy ? '0 : tagT'(bField);
		destTag     <= dest;
		do @(negedge clk); while (!dispatchAck);
		@(posedge clk);
		dispatchReq <= 1'b0;
		do @(negedge clk); while (dispatchAck);  // Phase four done
	endtask

	task automatic waitDrain();
		do @(negedge clk); while (|pending);
	endtask

	// Flushed tags leave the model, so any later result for them is an error
	task automatic flushStation(input int first, input int last);
		@(posedge clk);
		flush <= 1'b1;
		for (int t = first; t <= last; t++) pending[t] = 1'b0;
		@(posedge clk);
		flush <= 1'b0;
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		if (totalErrors() > errorsBefore) testsFailed++;
		$display("Test %0d %s: %s", testsRun, name, (totalErrors() > errorsBefore) ? "FAIL" : "ok");
		errorsBefore = totalErrors();
	endtask

	// Result bus monitor, one sample per valid cycle
	always @(negedge clk) begin
		if (rstN && resultValid) begin
			if (!pending[resultTag]) begin
				tbErrors++;
				$display("At %0t ns a result came for tag %0d, which was not owed", $time, resultTag);
			end else begin
				if (resultValue !== expValue[resultTag]) begin
					tbErrors++;
					$display("Mismatch at %0t ns: tag %0d gave %h, expected %h", $time,
						resultTag, resultValue, expValue[resultTag]);
				end
				pending[resultTag] = 1'b0;
			end
		end
	end

	initial begin
		dataT gateA;
		dataT gateB;
		rstN = 1'b0;
		dispatchReq = 1'b0;
		dispatchOp = opAdd;
		srcAValue = '0;
		srcATag = '0;
		srcAReady = 1'b0;
		srcBValue = '0;
		srcBTag = '0;
		srcBReady = 1'b0;
		destTag = '0;
		flush = 1'b0;
		repeat (2) @(posedge clk);
		rstN <= 1'b1;
		repeat (4) begin
			@(negedge clk);
			if (dispatchAck || resultValid || full) begin
				tbErrors++;
				$display("Outputs were active at %0t ns before any dispatch", $time);
			end
		end
		finishTest("reset");

		for (int k = 0; k < 12; k++)
			sendOp(aluOpT'(k % 6), 1'b1, randomValue(), 1'b1, randomValue(), tagT'(k));
		waitDrain();
		finishTest("independent ops");

		// Chain head waits on tag 4, sent last so no wakeup is missed
		gateA = randomValue();
		gateB = randomValue();
		expValue[4] = aluModel(opAdd, gateA, gateB);
		sendOp(opAdd, 1'b0, 4, 1'b1, randomValue(), 5);
		sendOp(opAdd, 1'b0, 5, 1'b1, randomValue(), 6);
		sendOp(opAdd, 1'b0, 6, 1'b1, randomValue(), 7);
		sendOp(opAdd, 1'b1, gateA, 1'b1, gateB, 4);
		waitDrain();
		finishTest("dependency chain");

		// Four waiters on tag 15, its producer must stall until a flush frees room
		for (int k = 8; k < 12; k++) sendOp(opOr, 1'b0, 15, 1'b1, randomValue(), tagT'(k));
		fork
			sendOp(opXor, 1'b1, randomValue(), 1'b1, randomValue(), 15);
			begin
				repeat (8) @(negedge clk);
				if (!full || dispatchAck) begin
					tbErrors++;
					$display("Fifth dispatch was not held off with all four entries waiting");
				end
				flushStation(8, 11);
			end
		join
		waitDrain();
		finishTest("back-pressure");

		// Three waiters wake together and contend for the ALU
		gateA = randomValue();
		gateB = randomValue();
		expValue[3] = aluModel(opAnd, gateA, gateB);
		sendOp(opAdd, 1'b0, 3, 1'b1, randomValue(), 0);
		sendOp(opSub, 1'b0, 3, 1'b1, randomValue(), 1);
		sendOp(opSlt, 1'b0, 3, 1'b1, randomValue(), 2);
		sendOp(opAnd, 1'b1, gateA, 1'b1, gateB, 3);
		waitDrain();
		finishTest("fairness");

		sendOp(opAdd, 1'b0, 10, 1'b1, randomValue(), 8);
		sendOp(opSub, 1'b1, randomValue(), 1'b0, 10, 9);
		flushStation(8, 9);
		sendOp(opXor, 1'b1, randomValue(), 1'b1, randomValue(), 10); // Would wake survivors
		sendOp(opSlt, 1'b1, randomValue(), 1'b1, randomValue(), 8);
		sendOp(opOr, 1'b1, randomValue(), 1'b1, randomValue(), 9);
		sendOp(opSub, 1'b1, randomValue(), 1'b1, randomValue(), 12);
		waitDrain();
		repeat (4) @(negedge clk);        // Let any stray result show up
		finishTest("flush");

		$display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, totalErrors());
		if (totalErrors() == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		repeat (watchdogCycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles with the tests still running", watchdogCycles);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- tests/aluIssue_assertions.sv
// Bound into aluIssueTop; the fairness bound assumes a strict rotating pointer and counts grants only
`include "aluIssue_params.svh"

module aluIssueAssertions import aluIssuePkg::*; (
	input logic     clk,
	input logic     rstN,
	input logic     dispatchReq,
	input logic     dispatchAck,
	input logic     full,
	input logic     resultValid,
	input logic     flushAll,
	input slotMaskT readyMask,
	input slotMaskT grant
);
	timeunit 1ns;
	timeprecision 1ps;

	int failCount = 0;                 // Summed into the testbench error count
	int othersGranted [`RS_ENTRIES];   // Grants elsewhere while this slot waits
	logic sawDispatch;                 // First dispatchReq seen since reset

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			sawDispatch <= 1'b0;
			for (int i = 0; i < `RS_ENTRIES; i++) othersGranted[i] <= 0;
		end else begin
			if (dispatchReq) sawDispatch <= 1'b1;
			for (int i = 0; i < `RS_ENTRIES; i++) begin
				if (!readyMask[i] || grant[i] || flushAll)
					othersGranted[i] <= 0;     // Served, gone or flushed
				else if (|grant)
					othersGranted[i] <= othersGranted[i] + 1;
			end
		end
	end

	// Quiet outputs from reset up to the first request
	assertResetQuiet: assert property (@(posedge clk) disable iff (!rstN)
		!sawDispatch |-> !dispatchAck && !resultValid && !full)
		else begin failCount++; $error("Outputs were not idle before the first dispatch"); end

	// Four-phase rules, ack only answers a req and drops after it
	assertAckNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
		$rose(dispatchAck) |-> $past(dispatchReq))
		else begin failCount++; $error("dispatchAck rose without dispatchReq"); end

	assertAckFallsLate: assert property (@(posedge clk) disable iff (!rstN)
		$fell(dispatchAck) |-> $past(!dispatchReq))
		else begin failCount++; $error("dispatchAck fell while dispatchReq was high"); end

	// A pending req with room must be taken on the next edge
	assertNoLostDispatch: assert property (@(posedge clk) disable iff (!rstN)
		dispatchReq && !dispatchAck && !full && !flushAll |=> dispatchAck)
		else begin failCount++; $error("Dispatch request ignored with a free slot"); end

	assertGrantLegal: assert property (@(posedge clk) disable iff (!rstN)
		$onehot0(grant) && ((grant & ~readyMask) == '0))
		else begin failCount++; $error("Grant not one-hot or not within readyMask"); end

	for (genvar i = 0; i < `RS_ENTRIES; i++) begin : gFair
		assertFair: assert property (@(posedge clk) disable iff (!rstN)
			othersGranted[i] < `RS_ENTRIES)
			else begin failCount++; $error("Ready entry starved by round-robin"); end
	end

endmodule

bind aluIssueTop aluIssueAssertions uAsserts (
	.clk, .rstN, .dispatchReq, .dispatchAck, .full, .resultValid,
	.flushAll, .readyMask, .grant
);
